// ==== common/armIsaPkg.sv ====
// ARM-style ISA definitions for the decode-stage sequencer; nv is treated as never, not as an extension space
package armIsaPkg;

	localparam int wordWidth = 32;       // Instruction and data word
	localparam int regListWidth = 16;    // LDM/STM register list bits [15:0]

	typedef logic [3:0] regIdx;          // Architectural register number

	// Micro-op register fields reuse R15 and R14 numbers
	localparam regIdx rzRegIdx = 4'd15;  // Scratch Rz, selected with the fifth address bit
	localparam regIdx lrRegIdx = 4'd14;  // Link register

	// Condition field, instr[31:28]
	typedef enum logic [3:0] {
		eq = 4'b0000,  // Z set
		ne = 4'b0001,  // Z clear
		cs = 4'b0010,  // C set
		cc = 4'b0011,  // C clear
		mi = 4'b0100,  // N set
		pl = 4'b0101,  // N clear
		vs = 4'b0110,  // V set
		vc = 4'b0111,  // V clear
		hi = 4'b1000,  // Unsigned higher
		ls = 4'b1001,  // Unsigned lower or same
		ge = 4'b1010,  // Signed greater or equal
		lt = 4'b1011,  // Signed less than
		gt = 4'b1100,  // Signed greater than
		le = 4'b1101,  // Signed less or equal
		al = 4'b1110,  // Always
		nv = 4'b1111   // Never
	} condCode;

	// CPSR flag nibble, same bit order as CPSR[31:28]
	typedef struct packed {
		logic n;  // Negative
		logic z;  // Zero
		logic c;  // Carry
		logic v;  // Overflow
	} armFlags;

endpackage

// ==== common/uOpPkg.sv ====
// Sequencer types; rz select bits only steer the fifth register address bit, the datapath owns Rz
package uOpPkg;

	// Sequencer FSM states
	typedef enum logic [2:0] {
		ready,     // Pass-through or first micro-op
		rsr,       // Second half of register-shifted-register op
		multiply,  // Add or accumulate after MUL into Rz
		bl,        // Plain branch after link move
		ldm,       // Load-multiple word walk
		stm        // Store-multiple word walk
	} seqState;

	// Decode classes, one per expansion
	typedef enum logic [2:0] {
		plain,       // Runs in one pass
		rsrOp,       // Data op with register-specified shift
		mulAcc,      // MLA, UMLAL, SMLAL
		branchLink,  // BL
		blockLoad,   // LDM
		blockStore   // STM
	} instrClass;

	// Register file port steering toward Rz
	typedef struct packed {
		logic ra1Init;  // Initial mux for read address 1
		logic wa3Rz;    // Write port goes to Rz
		logic ra2Rz;    // Read port 2 reads Rz
		logic ra1Rz;    // Read port 1 reads Rz
	} rzSelect;

	// Control bundle sent down the pipe with the micro-op
	typedef struct packed {
		logic    instrMux;      // Use micro-op instead of fetched word
		logic    holdFlags;     // No flag write this micro-op
		logic    uOpStall;      // Freeze fetch, more micro-ops follow
		logic    keepV;         // Preserve overflow across the multiply
		logic    prevRsr;       // Previous micro-op wrote Rz
		logic    blockForward;  // Forward Rz address between block words
		rzSelect rz;            // Fifth address bits
	} uOpCtrl;

endpackage

// ==== microSequencer/uOpFormer.sv ====
// Micro-op word builder; filler choice in LDM/STM follows blockForward from the sequencer
`timescale 1ns/100ps

module uOpFormer (
	input  logic [armIsaPkg::wordWidth-1:0] instr,
	input  uOpPkg::seqState                 state,
	input  uOpPkg::instrClass               cls,
	input  armIsaPkg::regIdx                nextReg,
	input  logic [11:0]                     startOffset,
	input  logic                            addUp,
	input  logic                            blockForward,
	output logic [armIsaPkg::wordWidth-1:0] uOpInstr
);

	logic [3:0]                      cond;        // Original condition, kept on every micro-op
	logic [armIsaPkg::wordWidth-1:0] fillerOp;    // ADD R0, R0, #0 with S clear
	logic [armIsaPkg::wordWidth-1:0] laterWord;   // Single transfer at Rz + 4

	assign cond = instr[31:28];

	assign fillerOp = {cond, 3'b001, 4'b0100, 1'b0, 20'b0};

	assign laterWord = {cond, 3'b010,
		1'b1,                   // P, pre-indexed
		1'b1,                   // U, add
		1'b0,                   // B, word access
		1'b0,                   // W, no writeback
		instr[20],              // L from the block op
		armIsaPkg::rzRegIdx,    // Base is Rz
		nextReg,
		12'd4};

	always_comb begin
		uOpInstr = instr;                                  // Plain pass-through
		case (state)
			uOpPkg::ready: begin
				case (cls)
					uOpPkg::rsrOp: begin               // MOV Rz, Rm shift Rs
						uOpInstr = {instr[31:25], 4'b1101, 1'b0,
							4'b0000, armIsaPkg::rzRegIdx, instr[11:0]};
					end
					uOpPkg::mulAcc: begin              // MUL Rz, Rm, Rs keeping sign bit
						uOpInstr = {instr[31:24], 1'b0, instr[22], 1'b0, 1'b0,
							armIsaPkg::rzRegIdx, 4'b0000, instr[11:0]};
					end
					uOpPkg::branchLink: begin          // MOV LR, PC
						uOpInstr = {cond, 3'b000, 4'b1101, 1'b0,
							4'b0000, armIsaPkg::lrRegIdx, 8'h00, 4'hF};
					end
					uOpPkg::blockLoad, uOpPkg::blockStore: begin
						uOpInstr = {cond, 3'b010,
							1'b1,              // Pre-indexed
							addUp,             // Direction from P/U mode
							1'b0,              // Word access
							1'b0,              // No writeback
							instr[20],
							instr[19:16],      // Base Rn
							nextReg,           // Lowest listed register
							startOffset};
					end
					default: uOpInstr = instr;
				endcase
			end
			uOpPkg::rsr: begin                             // Original op, Rz unshifted
				uOpInstr = {instr[31:12], 8'h00, armIsaPkg::rzRegIdx};
			end
			uOpPkg::multiply: begin
				if (!instr[23]) begin                      // MLA, ADD Rd, Rz, Rn
					uOpInstr = {cond, 7'b0000100, instr[20],
						armIsaPkg::rzRegIdx, instr[19:16], 8'h00, instr[15:12]};
				end else begin                             // RdLo and RdHi into the accumulator
					uOpInstr = {instr[31:16], instr[15:12], instr[15:12],
						4'b1001, instr[19:16]};
				end
			end
			uOpPkg::bl: begin                              // Plain B, link bit cleared
				uOpInstr = {instr[31:25], 1'b0, instr[23:0]};
			end
			uOpPkg::ldm, uOpPkg::stm: begin
				uOpInstr = blockForward ? laterWord : fillerOp;  // Filler on empty list or fail
			end
			default: uOpInstr = instr;
		endcase
	end

endmodule

// ==== microSequencer/uOpSequencer.sv ====
// Mealy sequencer; stall is a plain level that freezes the state while the outputs follow the held state
`timescale 1ns/100ps

module uOpSequencer (
	input  logic              clk,
	input  logic              reset,
	input  logic              stall,
	input  uOpPkg::instrClass cls,
	input  logic              condPass,
	input  logic [4:0]        remaining,
	output uOpPkg::seqState   state,
	output uOpPkg::uOpCtrl    ctrl
);

	uOpPkg::seqState nextState;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uOpPkg::ready;
		end else if (!stall) begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = uOpPkg::ready;
		ctrl = '0;                                         // Plain pass-through
		case (state)
			uOpPkg::ready: begin
				case (cls)
					uOpPkg::rsrOp: begin
						ctrl.instrMux = 1'b1;
						ctrl.holdFlags = 1'b1;             // Shift must not touch flags
						ctrl.uOpStall = 1'b1;
						ctrl.rz.ra1Init = 1'b1;
						ctrl.rz.wa3Rz = 1'b1;              // Shift result into Rz
						nextState = uOpPkg::rsr;
					end
					uOpPkg::mulAcc: begin
						ctrl.instrMux = 1'b1;
						ctrl.uOpStall = 1'b1;
						ctrl.keepV = 1'b1;
						ctrl.rz.ra1Init = 1'b1;
						ctrl.rz.wa3Rz = 1'b1;              // Product into Rz
						nextState = uOpPkg::multiply;
					end
					uOpPkg::branchLink: begin
						ctrl.instrMux = 1'b1;
						ctrl.uOpStall = 1'b1;              // LR move first
						nextState = uOpPkg::bl;
					end
					uOpPkg::blockLoad, uOpPkg::blockStore: begin
						ctrl.instrMux = 1'b1;
						ctrl.holdFlags = 1'b1;
						ctrl.uOpStall = 1'b1;              // First word from Rn
						nextState = (cls == uOpPkg::blockLoad) ? uOpPkg::ldm : uOpPkg::stm;
					end
					default: nextState = uOpPkg::ready;
				endcase
			end
			uOpPkg::rsr: begin
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				ctrl.rz.ra2Rz = 1'b1;                      // Rz as operand 2
			end
			uOpPkg::multiply: begin
				ctrl.instrMux = 1'b1;
				ctrl.holdFlags = 1'b1;
				ctrl.prevRsr = 1'b1;
				ctrl.rz.ra1Rz = 1'b1;                      // Rz product on read port 1
			end
			uOpPkg::bl: begin
				ctrl.instrMux = 1'b1;                      // Branch with L cleared
			end
			uOpPkg::ldm, uOpPkg::stm: begin
				ctrl.instrMux = 1'b1;
				ctrl.holdFlags = 1'b1;
				if (condPass && remaining != 5'd0) begin
					ctrl.blockForward = 1'b1;              // Real transfer at Rz + 4
					ctrl.rz.ra1Rz = 1'b1;
					if (remaining != 5'd1) begin
						ctrl.uOpStall = 1'b1;
						nextState = state;                 // More words to go
					end
				end
			end
			default: nextState = uOpPkg::ready;
		endcase
	end

	// Stall freezes the list walk along with the FSM
	assert property (@(posedge clk) disable iff (reset)
		stall && (state == uOpPkg::ldm || state == uOpPkg::stm) |=> $stable(remaining));

	// Fetch must be released on the cycle that returns to ready
	assert property (@(posedge clk) disable iff (reset)
		(!stall && state != uOpPkg::ready) ##1 (state == uOpPkg::ready)
		|-> $past(!ctrl.uOpStall));

endmodule

// ==== rtl/condCheck.sv ====
// Pure combinational condition table; flags are taken as already settled for the decode cycle
`timescale 1ns/100ps

module condCheck (
	input  armIsaPkg::condCode cond,
	input  armIsaPkg::armFlags flags,
	output logic               condPass
);

	logic nEqV;  // Signed compare helper

	assign nEqV = (flags.n == flags.v);

	always_comb begin
		case (cond)
			armIsaPkg::eq: condPass = flags.z;
			armIsaPkg::ne: condPass = !flags.z;
			armIsaPkg::cs: condPass = flags.c;
			armIsaPkg::cc: condPass = !flags.c;
			armIsaPkg::mi: condPass = flags.n;
			armIsaPkg::pl: condPass = !flags.n;
			armIsaPkg::vs: condPass = flags.v;
			armIsaPkg::vc: condPass = !flags.v;
			armIsaPkg::hi: condPass = flags.c && !flags.z;   // Unsigned >
			armIsaPkg::ls: condPass = !flags.c || flags.z;   // Unsigned <=
			armIsaPkg::ge: condPass = nEqV;
			armIsaPkg::lt: condPass = !nEqV;
			armIsaPkg::gt: condPass = !flags.z && nEqV;
			armIsaPkg::le: condPass = flags.z || !nEqV;
			armIsaPkg::al: condPass = 1'b1;
			armIsaPkg::nv: condPass = 1'b0;                 // Never
			default:       condPass = 1'b0;
		endcase
	end

endmodule

// ==== rtl/instrClassifier.sv ====
// Only the four expansion classes are recognized; single load/store and BLX decode as plain
`timescale 1ns/100ps

module instrClassifier (
	input  logic [armIsaPkg::wordWidth-1:0] instr,
	output uOpPkg::instrClass               cls
);

	logic isRsr;      // Register-shifted-register data op
	logic isMiscOp;   // Opcode 10xx with S clear lives in misc space
	logic isMulAcc;   // Multiply with accumulate bit
	logic isBl;       // Branch with link
	logic isBlock;    // Load/store multiple

	always_comb begin
		isMiscOp = (instr[24:23] == 2'b10) && !instr[20];  // BX, MRS and friends
		isRsr    = (instr[27:25] == 3'b000) && !instr[7] && instr[4] && !isMiscOp;
		isMulAcc = (instr[27:24] == 4'b0000) && (instr[7:4] == 4'b1001) && instr[21];
		isBl     = (instr[27:24] == 4'b1011);               // L bit set
		isBlock  = (instr[27:25] == 3'b100);
	end

	// Priority order matches the bit-pattern overlap
	always_comb begin
		if (isRsr) begin
			cls = uOpPkg::rsrOp;
		end else if (isMulAcc) begin
			cls = uOpPkg::mulAcc;           // Bit 7 set so never RSR
		end else if (isBl) begin
			cls = uOpPkg::branchLink;
		end else if (isBlock) begin
			if (instr[20]) begin
				cls = uOpPkg::blockLoad;    // L bit
			end else begin
				cls = uOpPkg::blockStore;
			end
		end else begin
			cls = uOpPkg::plain;
		end
	end

endmodule

// ==== rtl/microOpUnit.sv ====
// Decode-stage micro-op sequencer top; all outputs are combinational from instr, flags and held state
`timescale 1ns/100ps

module microOpUnit (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [armIsaPkg::wordWidth-1:0] instr,
	input  armIsaPkg::armFlags              flags,
	input  logic                            stall,
	output logic [armIsaPkg::wordWidth-1:0] uOpInstr,
	output uOpPkg::uOpCtrl                  ctrl
);

	uOpPkg::instrClass cls;
	uOpPkg::seqState   state;
	logic              condPass;
	logic [4:0]        remaining;
	armIsaPkg::regIdx  nextReg;
	logic [11:0]       startOffset;
	logic              addUp;

	instrClassifier classifier (
		.instr (instr),
		.cls   (cls)
	);

	condCheck condUnit (
		.cond     (armIsaPkg::condCode'(instr[31:28])),
		.flags    (flags),
		.condPass (condPass)
	);

	regListTracker tracker (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.instr       (instr),
		.state       (state),
		.cls         (cls),
		.remaining   (remaining),
		.nextReg     (nextReg),
		.startOffset (startOffset),
		.addUp       (addUp)
	);

	uOpSequencer sequencer (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.cls       (cls),
		.condPass  (condPass),
		.remaining (remaining),
		.state     (state),
		.ctrl      (ctrl)
	);

	uOpFormer former (
		.instr        (instr),
		.state        (state),
		.cls          (cls),
		.nextReg      (nextReg),
		.startOffset  (startOffset),
		.addUp        (addUp),
		.blockForward (ctrl.blockForward),
		.uOpInstr     (uOpInstr)
	);

endmodule

// ==== rtl/regListTracker.sv ====
// Block-transfer list walker; an empty list at LDM/STM entry is illegal and base writeback is not handled
`timescale 1ns/100ps

module regListTracker (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 stall,
	input  logic [armIsaPkg::wordWidth-1:0]      instr,
	input  uOpPkg::seqState                      state,
	input  uOpPkg::instrClass                    cls,
	output logic [4:0]                           remaining,
	output armIsaPkg::regIdx                     nextReg,
	output logic [11:0]                          startOffset,
	output logic                                 addUp
);

	logic [armIsaPkg::regListWidth-1:0] listQ;       // Registers left after the current one
	logic [armIsaPkg::regListWidth-1:0] activeList;  // List the current cycle works from
	logic [armIsaPkg::regListWidth-1:0] trimmed;     // Active list without its lowest bit
	logic [armIsaPkg::regListWidth-1:0] listNext;
	logic [4:0]                         countM1;
	logic                               isBlock;
	logic                               walking;

	assign isBlock = (cls == uOpPkg::blockLoad) || (cls == uOpPkg::blockStore);
	assign walking = (state == uOpPkg::ldm) || (state == uOpPkg::stm);

	// Ready looks at the instruction's own list
	assign activeList = (state == uOpPkg::ready) ? instr[15:0] : listQ;
	assign trimmed    = activeList & (activeList - 1'b1);  // Drop lowest set bit
	assign remaining  = 5'($countones(activeList));
	assign countM1    = remaining - 5'd1;

	// Lowest set bit wins
	always_comb begin
		nextReg = '0;
		for (int i = armIsaPkg::regListWidth - 1; i >= 0; i--) begin
			if (activeList[i]) begin
				nextReg = armIsaPkg::regIdx'(i);
			end
		end
	end

	// P and U bits pick the first address
	always_comb begin
		case (instr[24:23])
			2'b00: begin                                   // DA, Rn - 4N + 4
				startOffset = 12'({countM1, 2'b00});
				addUp = 1'b0;
			end
			2'b01: begin                                   // IA, Rn
				startOffset = 12'd0;
				addUp = 1'b1;
			end
			2'b10: begin                                   // DB, Rn - 4N
				startOffset = 12'({remaining, 2'b00});
				addUp = 1'b0;
			end
			default: begin                                 // IB, Rn + 4
				startOffset = 12'd4;
				addUp = 1'b1;
			end
		endcase
	end

	always_comb begin
		listNext = listQ;                                  // Hold outside block walks
		if (walking || (state == uOpPkg::ready && isBlock)) begin
			listNext = trimmed;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			listQ <= '0;
		end else if (!stall) begin
			listQ <= listNext;
		end
	end

	// A block transfer must list at least one register
	assert property (@(posedge clk) disable iff (reset)
		(state == uOpPkg::ready && isBlock) |-> (remaining != 5'd0));

endmodule

// ==== sources.f ====
common/armIsaPkg.sv
common/uOpPkg.sv
rtl/instrClassifier.sv
rtl/condCheck.sv
rtl/regListTracker.sv
microSequencer/uOpSequencer.sv
microSequencer/uOpFormer.sv
rtl/microOpUnit.sv
verif/tbMicroOpUnit.sv

// ==== verif/microOpGolden.mem ====
// Columns: id _ instr _ flags(nzcv) _ stall _ expected uOpInstr _ expected ctrl (10 bits in 3 hex)
// One decode cycle per line; id tags the test group
1_e0812003_0_0_e0812003_000
1_e3a00005_0_0_e3a00005_000
2_e0812314_0_0_e1a0f314_38c
2_e0812314_0_0_e081200f_222
3_e0214392_0_1_e00f0392_2cc
3_e0214392_0_0_e00f0392_2cc
3_e0214392_0_0_e08f1004_321
4_e0a32594_0_0_e00f0594_2cc
4_e0a32594_0_0_e0a32293_321
5_eb000010_0_0_e1a0e00f_280
5_eb000010_0_0_ea000010_200
6_e8900052_0_0_e5901000_380
6_e8900052_0_1_e59f4004_391
6_e8900052_0_0_e59f4004_391
6_e8900052_0_0_e59f6004_311
7_e90dffff_0_0_e50d0040_380
7_e90dffff_0_0_e58f1004_391
7_e90dffff_0_0_e58f2004_391
7_e90dffff_0_0_e58f3004_391
7_e90dffff_0_0_e58f4004_391
7_e90dffff_0_0_e58f5004_391
7_e90dffff_0_0_e58f6004_391
7_e90dffff_0_0_e58f7004_391
7_e90dffff_0_0_e58f8004_391
7_e90dffff_0_0_e58f9004_391
7_e90dffff_0_0_e58fa004_391
7_e90dffff_0_0_e58fb004_391
7_e90dffff_0_0_e58fc004_391
7_e90dffff_0_0_e58fd004_391
7_e90dffff_0_0_e58fe004_391
7_e90dffff_0_0_e58ff004_311
8_e9920080_0_0_e5927004_380
8_e9920080_0_0_e2800000_300
9_0805020c_2_0_05052008_380
9_0805020c_2_0_02800000_300
a_c9130003_8_0_c5130008_380
a_c9130003_8_0_c2800000_300
b_e1a00000_0_0_e1a00000_000

// ==== verif/tbMicroOpUnit.sv ====
// Replays golden vectors back to back; every sequence in the file must run to completion before the next group
`timescale 1ns/100ps

module tbMicroOpUnit;

	localparam int halfPeriod = 20;      // 40 ns clock
	localparam int driveDelay = 2;       // Inputs change just after the edge
	localparam int sampleDelay = 36;     // Checks 2 ns before the next edge
	localparam int resetCycles = 8;
	localparam int maxVectors = 64;
	localparam int numRandom = 8;        // Random plain words after the replay

	logic                            clk;
	logic                            reset;
	logic [armIsaPkg::wordWidth-1:0] instr;
	armIsaPkg::armFlags              flags;
	logic                            stall;
	logic [armIsaPkg::wordWidth-1:0] uOpInstr;
	uOpPkg::uOpCtrl                  ctrl;

	logic [87:0] vectors [0:maxVectors-1];  // id, instr, flags, stall, uOpInstr, ctrl
	logic [3:0]  testId;
	logic [3:0]  flagsField;
	logic [3:0]  stallField;                // Only bit 0 used
	logic [31:0] expInstr;
	logic [11:0] expCtrl;                   // Upper two bits unused
	logic [31:0] rnd;
	integer      seed;
	int          numVectors;
	int          cycleCount;
	int          cycleLimit;
	int          checkCount;
	int          instrErrors;
	int          ctrlErrors;
	int          otherErrors;

	microOpUnit dut (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.flags    (flags),
		.stall    (stall),
		.uOpInstr (uOpInstr),
		.ctrl     (ctrl)
	);

	always #(halfPeriod) clk = ~clk;

	// Group tags used in the golden file
	function automatic string testName(input logic [3:0] id);
		case (id)
			4'h1: return "plainAfterReset";
			4'h2: return "rsrAdd";
			4'h3: return "mlaShortStalled";
			4'h4: return "umlalLong";
			4'h5: return "branchLink";
			4'h6: return "ldmiaStall";
			4'h7: return "stmdbFullList";
			4'h8: return "ldmibSingle";
			4'h9: return "stmdaEqFail";
			4'ha: return "ldmdbGtFail";
			4'hb: return "plainClosing";
			default: return "unknownGroup";
		endcase
	endfunction

	task automatic checkOutputs(input string name, input logic [31:0] wantInstr,
		input logic [9:0] wantCtrl);
		checkCount++;
		assert (uOpInstr === wantInstr) else begin
			$display("ERR %s uOpInstr expected %h actual %h", name, wantInstr, uOpInstr);
			instrErrors++;
		end
		assert (ctrl === wantCtrl) else begin
			$display("ERR %s ctrl expected %h actual %h", name, wantCtrl, ctrl);
			ctrlErrors++;
		end
	endtask

	// Run guard with the limit set once the file is counted
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout, run still going after %0d cycles", cycleLimit);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr = '0;
		flags = '0;
		stall = 1'b0;
		seed = 32'ha4a0_2f4a;
		numVectors = 0;
		cycleCount = 0;
		checkCount = 0;
		instrErrors = 0;
		ctrlErrors = 0;
		otherErrors = 0;
		$readmemh("verif/microOpGolden.mem", vectors);
		while (numVectors < maxVectors && !$isunknown(vectors[numVectors])) begin
			numVectors++;                           // Unloaded entries stay X
		end
		cycleLimit = resetCycles + numVectors + numRandom + 20;  // Idle cycle fits in margin
		assert (numVectors > 0) else begin
			$display("Golden file is missing or holds no vectors");
			otherErrors++;
		end

		repeat (resetCycles) @(posedge clk);
		#(driveDelay);
		reset = 1'b0;

		// One line per decode cycle with the decode word held across a sequence
		for (int i = 0; i < numVectors; i++) begin
			@(posedge clk);
			#(driveDelay);
			{testId, instr, flagsField, stallField, expInstr, expCtrl} = vectors[i];
			flags = armIsaPkg::armFlags'(flagsField);
			stall = stallField[0];
			#(sampleDelay);
			checkOutputs(testName(testId), expInstr, expCtrl[9:0]);
		end

		// ADD immediate with random registers and immediate passes through
		for (int r = 0; r < numRandom; r++) begin
			@(posedge clk);
			#(driveDelay);
			rnd = $random(seed);
			instr = {12'he28, rnd[19:0]};
			flags = armIsaPkg::armFlags'(rnd[31:28]);
			stall = 1'b0;
			#(sampleDelay);
			checkOutputs("plainRandom", instr, 10'h000);
		end

		$display("Checks %0d, uOpInstr errors %0d, ctrl errors %0d, other errors %0d",
			checkCount, instrErrors, ctrlErrors, otherErrors);
		if (instrErrors + ctrlErrors + otherErrors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
